//--- Bender.yml
package:
  name: csr_unit

sources:
  - files:
      - csr_pkg.sv
      - csr_port_if.sv
      - csr_trap_if.sv
      - csr_access.sv
      - csr_trap_ctrl.sv
      - csr_machine_regs.sv
      - csr_unit.sv
  - target: test
    files:
      - csr_assertions.sv
      - tb_csr_unit.sv

//--- all.f
csr_pkg.sv
csr_port_if.sv
csr_trap_if.sv
csr_access.sv
csr_trap_ctrl.sv
csr_machine_regs.sv
csr_unit.sv
csr_assertions.sv
tb_csr_unit.sv

//--- csr_access.sv
module csr_access
(
   input  logic                           cmd_v_i,
   input  csr_pkg::csr_op_e               cmd_op_i,
   input  logic [csr_pkg::CSR_ADDR_W-1:0] cmd_addr_i,
   input  logic [csr_pkg::XLEN-1:0]       cmd_data_i,
   input  csr_pkg::priv_e                 priv_mode_i,
   input  logic                           mstatus_tw_i,
   input  logic [2:0]                     mcounteren_i,
   csr_port_if.decoder                    port,
   csr_trap_if.ret                        trap,
   output logic                           take_irq_v_o,
   output logic [csr_pkg::XLEN-1:0]       data_o,
   output logic                           illegal_o
);

   logic [csr_pkg::XLEN-1:0] operand;
   logic [csr_pkg::XLEN-1:0] new_value;
   logic                     is_imm;
   logic                     is_write_op;
   logic                     csr_v;
   logic                     mret_v;
   logic                     wfi_v;
   logic                     in_user;
   logic                     counter_denied;
   logic                     csr_illegal;

   assign in_user = (priv_mode_i == csr_pkg::PRIV_U);

   assign is_imm = cmd_op_i inside {csr_pkg::OP_CSRRWI, csr_pkg::OP_CSRRSI,
                                    csr_pkg::OP_CSRRCI};
   assign is_write_op = cmd_op_i inside {csr_pkg::OP_CSRRW, csr_pkg::OP_CSRRWI};

   assign csr_v  = cmd_v_i & (is_imm | is_write_op
                              | (cmd_op_i inside {csr_pkg::OP_CSRRS, csr_pkg::OP_CSRRC}));
   assign mret_v = cmd_v_i & (cmd_op_i == csr_pkg::OP_MRET);
   assign wfi_v  = cmd_v_i & (cmd_op_i == csr_pkg::OP_WFI);

   // Immediate forms use the zero-extended 5-bit zimm
   assign operand = is_imm ? csr_pkg::XLEN'(cmd_data_i[4:0]) : cmd_data_i;

   always_comb
   begin
      case (cmd_op_i)
         csr_pkg::OP_CSRRW, csr_pkg::OP_CSRRWI: new_value = operand;
         csr_pkg::OP_CSRRS, csr_pkg::OP_CSRRSI: new_value = port.rdata | operand;
         csr_pkg::OP_CSRRC, csr_pkg::OP_CSRRCI: new_value = port.rdata & ~operand;
         default:                               new_value = port.rdata;
      endcase
   end

   // User access to the counter aliases needs mcounteren
   assign counter_denied = in_user
                           & (((cmd_addr_i == csr_pkg::ADDR_CYCLE) & ~mcounteren_i[0])
                              | ((cmd_addr_i == csr_pkg::ADDR_INSTRET) & ~mcounteren_i[2]));

   assign csr_illegal = (cmd_addr_i[9:8] > priv_mode_i) | ~port.hit | counter_denied;

   assign illegal_o = (csr_v & csr_illegal)
                      | (mret_v & (priv_mode_i != csr_pkg::PRIV_M))
                      | (wfi_v & in_user & mstatus_tw_i);

   assign port.csr_addr = cmd_addr_i;
   assign port.wdata    = new_value;
   // Set and clear with a zero operand leave the register alone
   assign port.we       = csr_v & ~csr_illegal & (is_write_op | (operand != '0));

   assign data_o = (csr_v & ~csr_illegal) ? port.rdata : '0;

   assign trap.ret_v   = mret_v & (priv_mode_i == csr_pkg::PRIV_M);
   assign take_irq_v_o = cmd_v_i & (cmd_op_i == csr_pkg::OP_TAKE_IRQ);

endmodule

//--- csr_assertions.sv
module csr_unit_assertions
(
   input logic           clk_i,
   input logic           rst_n_i,
   input logic           csr_cmd_v_i,
   input logic           v_o,
   input logic           trap_v_o,
   input logic           eret_v_o,
   input csr_pkg::priv_e priv_mode_o
);

   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;

   valid_follows_cmd: assert property (@(posedge clk_i) v_o == csr_cmd_v_i)
      else
      begin
         $error("v_o does not follow csr_cmd_v_i");
         fail_count++;
      end

   trap_excludes_return: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                          !(trap_v_o && eret_v_o))
      else
      begin
         $error("trap_v_o and eret_v_o high together");
         fail_count++;
      end

   reset_to_machine: assert property (@(posedge clk_i)
                                      !rst_n_i |=> priv_mode_o == csr_pkg::PRIV_M)
      else
      begin
         $error("privilege mode is not M after reset");
         fail_count++;
      end

endmodule

bind csr_unit csr_unit_assertions u_assertions (.*);

//--- csr_machine_regs.sv
module csr_machine_regs
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic [csr_pkg::XLEN-1:0] hartid_i,
   input  logic                     instret_i,
   input  logic                     timer_irq_i,
   input  logic                     software_irq_i,
   input  logic                     external_irq_i,
   csr_port_if.regfile              port,
   csr_trap_if.sink                 trap,
   output csr_pkg::priv_e           priv_mode_o,
   output csr_pkg::mstatus_t        mstatus_o,
   output csr_pkg::mip_t            mie_o,
   output csr_pkg::mip_t            mip_o,
   output logic [2:0]               mcounteren_o,
   output logic [csr_pkg::XLEN-1:0] tvec_o,
   output logic [csr_pkg::XLEN-1:0] epc_o
);

   csr_pkg::priv_e           priv_mode_r;
   csr_pkg::mstatus_t        mstatus_r;
   csr_pkg::mip_t            mie_r;
   csr_pkg::mip_t            mip_r;
   csr_pkg::mcause_t         mcause_r;
   logic [csr_pkg::XLEN-1:0] mtvec_r;
   logic [csr_pkg::XLEN-1:0] mscratch_r;
   logic [csr_pkg::XLEN-1:0] mepc_r;
   logic [csr_pkg::XLEN-1:0] mtval_r;
   logic [csr_pkg::XLEN-1:0] mcycle_r;
   logic [csr_pkg::XLEN-1:0] minstret_r;
   logic [2:0]               mcounteren_r;
   // Bit 1 (time) stays zero
   logic [2:0]               mcountinhibit_r;

   csr_pkg::mstatus_t        wr_status;
   csr_pkg::mip_t            wr_irq;

   assign wr_status = port.wdata;
   assign wr_irq    = port.wdata;

   always_comb
   begin
      port.hit   = 1'b1;
      port.rdata = '0;
      case (port.csr_addr)
         csr_pkg::ADDR_MSTATUS:       port.rdata = mstatus_r;
         csr_pkg::ADDR_MISA:          port.rdata = csr_pkg::MISA_VALUE;
         csr_pkg::ADDR_MIE:           port.rdata = mie_r;
         csr_pkg::ADDR_MTVEC:         port.rdata = mtvec_r;
         csr_pkg::ADDR_MCOUNTEREN:    port.rdata = csr_pkg::XLEN'(mcounteren_r);
         csr_pkg::ADDR_MCOUNTINHIBIT: port.rdata = csr_pkg::XLEN'(mcountinhibit_r);
         csr_pkg::ADDR_MSCRATCH:      port.rdata = mscratch_r;
         csr_pkg::ADDR_MEPC:          port.rdata = mepc_r;
         csr_pkg::ADDR_MCAUSE:        port.rdata = mcause_r;
         csr_pkg::ADDR_MTVAL:         port.rdata = mtval_r;
         csr_pkg::ADDR_MIP:           port.rdata = mip_r;
         csr_pkg::ADDR_MCYCLE,
         csr_pkg::ADDR_CYCLE:         port.rdata = mcycle_r;
         csr_pkg::ADDR_MINSTRET,
         csr_pkg::ADDR_INSTRET:       port.rdata = minstret_r;
         csr_pkg::ADDR_MVENDORID:     port.rdata = '0;
         csr_pkg::ADDR_MARCHID:       port.rdata = csr_pkg::MARCHID_VALUE;
         csr_pkg::ADDR_MIMPID:        port.rdata = csr_pkg::MIMPID_VALUE;
         csr_pkg::ADDR_MHARTID:       port.rdata = hartid_i;
         default:                     port.hit   = 1'b0;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         priv_mode_r     <= csr_pkg::PRIV_M;
         mstatus_r       <= '0;
         mie_r           <= '0;
         mip_r           <= '0;
         mcause_r        <= '0;
         mtvec_r         <= '0;
         mscratch_r      <= '0;
         mepc_r          <= '0;
         mtval_r         <= '0;
         mcycle_r        <= '0;
         minstret_r      <= '0;
         mcounteren_r    <= '0;
         mcountinhibit_r <= '0;
      end
      else
      begin
         if (!mcountinhibit_r[0])
            mcycle_r <= mcycle_r + 1'b1;
         if (instret_i && !mcountinhibit_r[2])
            minstret_r <= minstret_r + 1'b1;

         mip_r <= '{meip: external_irq_i, mtip: timer_irq_i, msip: software_irq_i,
                    default: '0};

         if (trap.trap_v)
         begin
            priv_mode_r    <= csr_pkg::PRIV_M;
            mstatus_r.mpp  <= priv_mode_r;
            mstatus_r.mpie <= mstatus_r.mie;
            mstatus_r.mie  <= 1'b0;
            mepc_r         <= trap.epc;
            mcause_r       <= trap.cause;
            mtval_r        <= trap.tval;
         end
         else if (trap.ret_v)
         begin
            priv_mode_r    <= mstatus_r.mpp;
            mstatus_r.mie  <= mstatus_r.mpie;
            mstatus_r.mpie <= 1'b1;
            mstatus_r.mpp  <= csr_pkg::PRIV_U;
            if (mstatus_r.mpp != csr_pkg::PRIV_M)
               mstatus_r.mprv <= 1'b0;
         end
         else if (port.we)
         begin
            // Read-only and unimplemented fields drop the write
            case (port.csr_addr)
               csr_pkg::ADDR_MSTATUS:
                  mstatus_r <= '{tw:      wr_status.tw,
                                 mprv:    wr_status.mprv,
                                 mpp:     (wr_status.mpp == csr_pkg::PRIV_M) ?
                                          csr_pkg::PRIV_M : csr_pkg::PRIV_U,
                                 mpie:    wr_status.mpie,
                                 mie:     wr_status.mie,
                                 default: '0};
               csr_pkg::ADDR_MIE:
                  mie_r <= '{meip: wr_irq.meip, mtip: wr_irq.mtip, msip: wr_irq.msip,
                             default: '0};
               csr_pkg::ADDR_MTVEC:         mtvec_r    <= port.wdata;
               csr_pkg::ADDR_MCOUNTEREN:    mcounteren_r <= port.wdata[2:0];
               csr_pkg::ADDR_MCOUNTINHIBIT:
                  mcountinhibit_r <= {port.wdata[2], 1'b0, port.wdata[0]};
               csr_pkg::ADDR_MSCRATCH:      mscratch_r <= port.wdata;
               csr_pkg::ADDR_MEPC:          mepc_r     <= port.wdata;
               csr_pkg::ADDR_MCAUSE:
                  mcause_r <= '{interrupt: port.wdata[csr_pkg::XLEN-1],
                                ecode:     port.wdata[csr_pkg::CAUSE_W-1:0],
                                default:   '0};
               csr_pkg::ADDR_MTVAL:         mtval_r    <= port.wdata;
               // Overrides this cycle's increment
               csr_pkg::ADDR_MCYCLE:        mcycle_r   <= port.wdata;
               csr_pkg::ADDR_MINSTRET:      minstret_r <= port.wdata;
               default:                     ;
            endcase
         end
      end
   end

   assign priv_mode_o  = priv_mode_r;
   assign mstatus_o    = mstatus_r;
   assign mie_o        = mie_r;
   assign mip_o        = mip_r;
   assign mcounteren_o = mcounteren_r;
   assign tvec_o       = {mtvec_r[csr_pkg::XLEN-1:2], 2'b00};
   assign epc_o        = mepc_r;

endmodule

//--- csr_pkg.sv
package csr_pkg;

   localparam int XLEN       = 64;
   localparam int VADDR_W    = 39;
   localparam int INSTR_W    = 32;
   localparam int ECODE_W    = 16;
   localparam int CAUSE_W    = 4;
   localparam int CSR_ADDR_W = 12;

   typedef enum logic [1:0] {
      PRIV_U = 2'd0,
      PRIV_M = 2'd3
   } priv_e;

   typedef enum logic [3:0] {
      OP_CSRRW,
      OP_CSRRS,
      OP_CSRRC,
      OP_CSRRWI,
      OP_CSRRSI,
      OP_CSRRCI,
      OP_MRET,
      OP_WFI,
      OP_TAKE_IRQ,
      OP_NONE
   } csr_op_e;

   localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS       = 12'h300;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MISA          = 12'h301;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MIE           = 12'h304;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC         = 12'h305;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCOUNTEREN    = 12'h306;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCOUNTINHIBIT = 12'h320;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH      = 12'h340;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC          = 12'h341;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE        = 12'h342;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL         = 12'h343;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MIP           = 12'h344;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLE        = 12'hB00;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRET      = 12'hB02;
   localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLE         = 12'hC00;
   localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRET       = 12'hC02;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MVENDORID     = 12'hF11;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MARCHID       = 12'hF12;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID        = 12'hF13;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID       = 12'hF14;

   // RV64 with A, I, S and U
   localparam logic [XLEN-1:0] MISA_VALUE    = {2'b10, 36'b0, 26'h140101};
   localparam logic [XLEN-1:0] MARCHID_VALUE = 64'd13;
   localparam logic [XLEN-1:0] MIMPID_VALUE  = 64'd1;

   localparam logic [CAUSE_W-1:0] ECODE_ILLEGAL = 4'd2;

   typedef struct packed {
      logic [63:22] zero5;
      logic         tw;
      logic [20:18] zero4;
      logic         mprv;
      logic [16:13] zero3;
      priv_e        mpp;
      logic [10:8]  zero2;
      logic         mpie;
      logic [6:4]   zero1;
      logic         mie;
      logic [2:0]   zero0;
   } mstatus_t;

   typedef struct packed {
      logic [63:12] zero3;
      logic         meip;
      logic [10:8]  zero2;
      logic         mtip;
      logic [6:4]   zero1;
      logic         msip;
      logic [2:0]   zero0;
   } mip_t;

   typedef struct packed {
      logic                      interrupt;
      logic [62:CAUSE_W]         zero0;
      logic [CAUSE_W-1:0]        ecode;
   } mcause_t;

endpackage

//--- csr_port_if.sv
interface csr_port_if;

   logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr;
   logic                           we;
   logic [csr_pkg::XLEN-1:0]       wdata;
   logic [csr_pkg::XLEN-1:0]       rdata;
   // Address names an implemented CSR
   logic                           hit;

   modport decoder (
      output csr_addr, we, wdata,
      input  rdata, hit
   );

   modport regfile (
      input  csr_addr, we, wdata,
      output rdata, hit
   );

endinterface

//--- csr_trap_ctrl.sv
module csr_trap_ctrl
(
   input  logic                           exception_v_i,
   input  logic [csr_pkg::ECODE_W-1:0]    exception_ecode_dec_i,
   input  logic [csr_pkg::VADDR_W-1:0]    exception_pc_i,
   input  logic [csr_pkg::VADDR_W-1:0]    exception_vaddr_i,
   input  logic [csr_pkg::INSTR_W-1:0]    exception_instr_i,
   input  logic                           take_irq_v_i,
   input  logic                           mstatus_mie_i,
   input  csr_pkg::mip_t                  mie_i,
   input  csr_pkg::mip_t                  mip_i,
   input  csr_pkg::priv_e                 priv_mode_i,
   csr_trap_if.source                     trap,
   output logic                           accept_irq_o
);

   // Index of the lowest set bit
   function automatic logic [csr_pkg::CAUSE_W-1:0] lowest_set
      (input logic [csr_pkg::ECODE_W-1:0] vec);
      logic [csr_pkg::CAUSE_W-1:0] idx;
      idx = '0;
      for (int i = csr_pkg::ECODE_W - 1; i >= 0; i--)
      begin
         if (vec[i])
            idx = csr_pkg::CAUSE_W'(i);
      end
      return idx;
   endfunction

   logic [csr_pkg::XLEN-1:0]    irq_pend;
   logic [csr_pkg::ECODE_W-1:0] irq_vec;
   logic                        global_en;
   logic [csr_pkg::CAUSE_W-1:0] irq_code;
   logic [csr_pkg::CAUSE_W-1:0] exc_code;
   logic                        exc_v;
   logic                        irq_v;

   // U mode interrupts are always enabled at M level
   assign global_en = (priv_mode_i == csr_pkg::PRIV_U) | mstatus_mie_i;

   assign irq_pend = mie_i & mip_i;
   assign irq_vec  = irq_pend[csr_pkg::ECODE_W-1:0] & {csr_pkg::ECODE_W{global_en}};

   assign irq_code = lowest_set(irq_vec);
   assign exc_code = lowest_set(exception_ecode_dec_i);

   assign accept_irq_o = |irq_vec;

   assign exc_v = exception_v_i & (|exception_ecode_dec_i);
   assign irq_v = take_irq_v_i & accept_irq_o;

   // Exceptions win over interrupts
   assign trap.trap_v = exc_v | irq_v;
   assign trap.cause  = '{interrupt: ~exc_v,
                          ecode:     exc_v ? exc_code : irq_code,
                          default:   '0};
   assign trap.epc    = csr_pkg::XLEN'($signed(exception_pc_i));

   always_comb
   begin
      if (!exc_v)
         trap.tval = '0;
      else if (exc_code == csr_pkg::ECODE_ILLEGAL)
         trap.tval = csr_pkg::XLEN'(exception_instr_i);
      else
         trap.tval = csr_pkg::XLEN'($signed(exception_vaddr_i));
   end

endmodule

//--- csr_trap_if.sv
interface csr_trap_if;

   logic                     trap_v;
   logic                     ret_v;
   csr_pkg::mcause_t         cause;
   logic [csr_pkg::XLEN-1:0] epc;
   logic [csr_pkg::XLEN-1:0] tval;

   modport source (
      output trap_v, cause, epc, tval
   );

   modport ret (
      output ret_v
   );

   modport sink (
      input trap_v, ret_v, cause, epc, tval
   );

endinterface

//--- csr_unit.sv
module csr_unit
(
   input  logic                           clk_i,
   input  logic                           rst_n_i,

   input  logic                           csr_cmd_v_i,
   input  csr_pkg::csr_op_e               csr_cmd_op_i,
   input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_cmd_addr_i,
   input  logic [csr_pkg::XLEN-1:0]       csr_cmd_data_i,

   input  logic [csr_pkg::XLEN-1:0]       hartid_i,
   input  logic                           instret_i,

   input  logic                           exception_v_i,
   input  logic [csr_pkg::ECODE_W-1:0]    exception_ecode_dec_i,
   input  logic [csr_pkg::VADDR_W-1:0]    exception_pc_i,
   input  logic [csr_pkg::VADDR_W-1:0]    exception_vaddr_i,
   input  logic [csr_pkg::INSTR_W-1:0]    exception_instr_i,

   input  logic                           timer_irq_i,
   input  logic                           software_irq_i,
   input  logic                           external_irq_i,

   output logic [csr_pkg::XLEN-1:0]       data_o,
   output logic                           v_o,
   output logic                           illegal_instr_o,
   output logic                           accept_irq_o,
   output logic                           trap_v_o,
   output logic                           eret_v_o,
   output logic [csr_pkg::XLEN-1:0]       tvec_o,
   output logic [csr_pkg::XLEN-1:0]       epc_o,
   output csr_pkg::priv_e                 priv_mode_o
);

   csr_port_if port_bus ();
   csr_trap_if trap_bus ();

   csr_pkg::priv_e    priv_mode;
   csr_pkg::mstatus_t mstatus;
   csr_pkg::mip_t     mie;
   csr_pkg::mip_t     mip;
   logic [2:0]        mcounteren;
   logic              take_irq_v;

   csr_access u_access (
      .cmd_v_i      (csr_cmd_v_i),
      .cmd_op_i     (csr_cmd_op_i),
      .cmd_addr_i   (csr_cmd_addr_i),
      .cmd_data_i   (csr_cmd_data_i),
      .priv_mode_i  (priv_mode),
      .mstatus_tw_i (mstatus.tw),
      .mcounteren_i (mcounteren),
      .port         (port_bus),
      .trap         (trap_bus),
      .take_irq_v_o (take_irq_v),
      .data_o       (data_o),
      .illegal_o    (illegal_instr_o)
   );

   csr_trap_ctrl u_trap_ctrl (
      .exception_v_i         (exception_v_i),
      .exception_ecode_dec_i (exception_ecode_dec_i),
      .exception_pc_i        (exception_pc_i),
      .exception_vaddr_i     (exception_vaddr_i),
      .exception_instr_i     (exception_instr_i),
      .take_irq_v_i          (take_irq_v),
      .mstatus_mie_i         (mstatus.mie),
      .mie_i                 (mie),
      .mip_i                 (mip),
      .priv_mode_i           (priv_mode),
      .trap                  (trap_bus),
      .accept_irq_o          (accept_irq_o)
   );

   csr_machine_regs u_regs (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .hartid_i       (hartid_i),
      .instret_i      (instret_i),
      .timer_irq_i    (timer_irq_i),
      .software_irq_i (software_irq_i),
      .external_irq_i (external_irq_i),
      .port           (port_bus),
      .trap           (trap_bus),
      .priv_mode_o    (priv_mode),
      .mstatus_o      (mstatus),
      .mie_o          (mie),
      .mip_o          (mip),
      .mcounteren_o   (mcounteren),
      .tvec_o         (tvec_o),
      .epc_o          (epc_o)
   );

   assign v_o      = csr_cmd_v_i;
   assign trap_v_o = trap_bus.trap_v;
   assign eret_v_o = trap_bus.ret_v;

   assign priv_mode_o = priv_mode;

endmodule

//--- tb_csr_unit.sv
module tb_csr_unit;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          CLK_PERIOD   = 10;
   localparam int          RESET_CYCLES = 16;
   localparam int          N_TESTS      = 5;
   // Upper bound on the cycles a single test needs
   localparam int          TEST_CYCLES  = 150;
   localparam logic [31:0] SEED         = 32'hcd4f_26aa;

   logic                           clk_i;
   logic                           rst_n_i;
   logic                           csr_cmd_v_i;
   csr_pkg::csr_op_e               csr_cmd_op_i;
   logic [csr_pkg::CSR_ADDR_W-1:0] csr_cmd_addr_i;
   logic [63:0]                    csr_cmd_data_i;
   logic [63:0]                    hartid_i;
   logic                           instret_i;
   logic                           exception_v_i;
   logic [15:0]                    exception_ecode_dec_i;
   logic [38:0]                    exception_pc_i;
   logic [38:0]                    exception_vaddr_i;
   logic [31:0]                    exception_instr_i;
   logic                           timer_irq_i;
   logic                           software_irq_i;
   logic                           external_irq_i;
   logic [63:0]                    data_o;
   logic                           v_o;
   logic                           illegal_instr_o;
   logic                           accept_irq_o;
   logic                           trap_v_o;
   logic                           eret_v_o;
   logic [63:0]                    tvec_o;
   logic [63:0]                    epc_o;
   csr_pkg::priv_e                 priv_mode_o;

   // Outputs captured at the falling edge of a command cycle
   logic [63:0]    rd;
   logic           v_s;
   logic           ill;
   logic           trap_s;
   logic           eret_s;
   logic           acc_s;
   logic [63:0]    tvec_s;
   logic [63:0]    epc_s;
   csr_pkg::priv_e priv_s;
   int             errors;
   int             checks;

   csr_unit DUT (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial
   begin
      #((RESET_CYCLES + N_TESTS * TEST_CYCLES) * CLK_PERIOD * 2);
      $display("Run timed out before all tests finished");
      $display("Something failed");
      $finish;
   end

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic capture_outputs();
      rd     = data_o;
      v_s    = v_o;
      ill    = illegal_instr_o;
      trap_s = trap_v_o;
      eret_s = eret_v_o;
      acc_s  = accept_irq_o;
      tvec_s = tvec_o;
      epc_s  = epc_o;
      priv_s = priv_mode_o;
   endtask

   // One command cycle followed by one idle cycle
   task automatic issue(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                        input logic [63:0] data);
      @(posedge clk_i);
      csr_cmd_v_i    <= 1'b1;
      csr_cmd_op_i   <= op;
      csr_cmd_addr_i <= addr;
      csr_cmd_data_i <= data;
      @(negedge clk_i);
      capture_outputs();
      @(posedge clk_i);
      csr_cmd_v_i  <= 1'b0;
      csr_cmd_op_i <= csr_pkg::OP_NONE;
   endtask

   task automatic read_csr(input logic [11:0] addr);
      issue(csr_pkg::OP_CSRRS, addr, '0);
   endtask

   task automatic write_csr(input logic [11:0] addr, input logic [63:0] value);
      issue(csr_pkg::OP_CSRRW, addr, value);
   endtask

   task automatic raise_exception(input logic [15:0] cause, input logic [38:0] pc,
                                  input logic [38:0] vaddr, input logic [31:0] instr);
      @(posedge clk_i);
      exception_v_i         <= 1'b1;
      exception_ecode_dec_i <= cause;
      exception_pc_i        <= pc;
      exception_vaddr_i     <= vaddr;
      exception_instr_i     <= instr;
      @(negedge clk_i);
      capture_outputs();
      @(posedge clk_i);
      exception_v_i <= 1'b0;
   endtask

   function automatic logic [63:0] expected_csr(input csr_pkg::csr_op_e op,
                                                input logic [63:0] old,
                                                input logic [63:0] src);
      logic [63:0] zimm;
      zimm = {59'b0, src[4:0]};
      case (op)
         csr_pkg::OP_CSRRW:  return src;
         csr_pkg::OP_CSRRS:  return old | src;
         csr_pkg::OP_CSRRC:  return old & ~src;
         csr_pkg::OP_CSRRWI: return zimm;
         csr_pkg::OP_CSRRSI: return old | zimm;
         default:            return old & ~zimm;
      endcase
   endfunction

   function automatic logic [3:0] first_set(input logic [15:0] vec);
      for (int i = 0; i < 16; i++)
      begin
         if (vec[i])
            return 4'(i);
      end
      return 4'd0;
   endfunction

   task automatic identity_and_access();
      csr_pkg::csr_op_e ops [6];
      logic [63:0]      model;
      logic [63:0]      src;
      ops = '{csr_pkg::OP_CSRRW, csr_pkg::OP_CSRRS, csr_pkg::OP_CSRRC,
              csr_pkg::OP_CSRRWI, csr_pkg::OP_CSRRSI, csr_pkg::OP_CSRRCI};
      read_csr(csr_pkg::ADDR_MISA);
      check("misa", rd, csr_pkg::MISA_VALUE);
      check("command valid", v_s, 1'b1);
      read_csr(csr_pkg::ADDR_MARCHID);
      check("marchid", rd, csr_pkg::MARCHID_VALUE);
      read_csr(csr_pkg::ADDR_MIMPID);
      check("mimpid", rd, csr_pkg::MIMPID_VALUE);
      read_csr(csr_pkg::ADDR_MHARTID);
      check("mhartid", rd, hartid_i);
      model = '0;
      foreach (ops[i])
      begin
         src = {$urandom, $urandom};
         issue(ops[i], csr_pkg::ADDR_MSCRATCH, src);
         check("mscratch old value", rd, model);
         check("mscratch access legal", ill, 1'b0);
         model = expected_csr(ops[i], model, src);
      end
      read_csr(csr_pkg::ADDR_MSCRATCH);
      check("mscratch final", rd, model);
   endtask

   task automatic privilege_checks();
      issue(csr_pkg::OP_CSRRS, 12'h7C0, '0);
      check("unknown address illegal", ill, 1'b1);
      write_csr(csr_pkg::ADDR_MSTATUS, '0);
      issue(csr_pkg::OP_MRET, '0, '0);
      check("mret in M legal", ill, 1'b0);
      read_csr(csr_pkg::ADDR_MSCRATCH);
      check("mode after mret", priv_s, csr_pkg::PRIV_U);
      check("M CSR from U illegal", ill, 1'b1);
      read_csr(csr_pkg::ADDR_CYCLE);
      check("cycle without mcounteren", ill, 1'b1);
      // Trap back to M to grant the counter
      raise_exception(16'h0001, '0, '0, '0);
      write_csr(csr_pkg::ADDR_MCOUNTEREN, 64'h1);
      write_csr(csr_pkg::ADDR_MSTATUS, '0);
      issue(csr_pkg::OP_MRET, '0, '0);
      read_csr(csr_pkg::ADDR_CYCLE);
      check("cycle with mcounteren", ill, 1'b0);
      check("mode is U", priv_s, csr_pkg::PRIV_U);
      issue(csr_pkg::OP_MRET, '0, '0);
      check("mret in U illegal", ill, 1'b1);
      check("no return from U", eret_s, 1'b0);
      raise_exception(16'h0001, '0, '0, '0);
      read_csr(csr_pkg::ADDR_MSCRATCH);
      check("mode after trap", priv_s, csr_pkg::PRIV_M);
   endtask

   task automatic exception_entry();
      logic [63:0] tvec;
      logic [38:0] pc;
      logic [38:0] vaddr;
      logic [31:0] instr;
      logic [15:0] cause;
      logic [3:0]  code;
      for (int n = 0; n < 2; n++)
      begin
         tvec  = {$urandom, $urandom};
         pc    = 39'({$urandom, $urandom});
         vaddr = 39'({$urandom, $urandom});
         instr = $urandom;
         cause = 16'($urandom);
         // Second pass forces the illegal cause
         if (n == 1)
            cause = {cause[15:3], 3'b100};
         else if (cause == '0)
            cause = 16'h0020;
         code = first_set(cause);
         write_csr(csr_pkg::ADDR_MTVEC, tvec);
         write_csr(csr_pkg::ADDR_MSTATUS, 64'h8);
         raise_exception(cause, pc, vaddr, instr);
         check("trap strobe", trap_s, 1'b1);
         check("trap vector", tvec_s, {tvec[63:2], 2'b00});
         read_csr(csr_pkg::ADDR_MCAUSE);
         check("mcause", rd, {60'b0, code});
         read_csr(csr_pkg::ADDR_MEPC);
         check("mepc", rd, {{25{pc[38]}}, pc});
         read_csr(csr_pkg::ADDR_MTVAL);
         check("mtval", rd, (code == 4'd2) ? {32'b0, instr} : {{25{vaddr[38]}}, vaddr});
         check("mode after exception", priv_s, csr_pkg::PRIV_M);
         read_csr(csr_pkg::ADDR_MSTATUS);
         check("mstatus mpie", rd[7], 1'b1);
         check("mstatus mie", rd[3], 1'b0);
      end
   endtask

   task automatic interrupt_entry();
      logic [2:0] lines;
      logic [3:0] code;
      write_csr(csr_pkg::ADDR_MIE, 64'h888);
      for (int r = 0; r < 3; r++)
      begin
         // Lines are external, timer, software
         lines = (r == 0) ? 3'b110 : (r == 1) ? 3'b111 : 3'b100;
         code  = lines[0] ? 4'd3 : lines[1] ? 4'd7 : 4'd11;
         write_csr(csr_pkg::ADDR_MSTATUS, 64'h8);
         @(posedge clk_i);
         external_irq_i <= lines[2];
         timer_irq_i    <= lines[1];
         software_irq_i <= lines[0];
         issue(csr_pkg::OP_TAKE_IRQ, '0, '0);
         check("interrupt accepted", acc_s, 1'b1);
         check("interrupt trap", trap_s, 1'b1);
         read_csr(csr_pkg::ADDR_MCAUSE);
         check("interrupt mcause", rd, {1'b1, 59'b0, code});
      end
      write_csr(csr_pkg::ADDR_MSTATUS, '0);
      read_csr(csr_pkg::ADDR_MSCRATCH);
      check("masked by mstatus.mie", acc_s, 1'b0);
      @(posedge clk_i);
      external_irq_i <= 1'b0;
      timer_irq_i    <= 1'b0;
      software_irq_i <= 1'b0;
   endtask

   task automatic counters_and_return();
      logic [63:0] c0;
      logic [63:0] epc_val;
      int          k;
      int          n;
      for (int inh = 0; inh < 2; inh++)
      begin
         write_csr(csr_pkg::ADDR_MCOUNTINHIBIT, (inh == 1) ? 64'h5 : 64'h0);
         k = 3 + $urandom % 16;
         read_csr(csr_pkg::ADDR_MCYCLE);
         c0 = rd;
         repeat (k) @(posedge clk_i);
         read_csr(csr_pkg::ADDR_MCYCLE);
         // Both reads bracket k idle cycles plus one command and one idle cycle
         check("mcycle delta", rd - c0, (inh == 1) ? 64'd0 : 64'(k + 2));
      end
      write_csr(csr_pkg::ADDR_MCOUNTINHIBIT, '0);
      n = 1 + $urandom % 10;
      read_csr(csr_pkg::ADDR_MINSTRET);
      c0 = rd;
      repeat (n)
      begin
         @(posedge clk_i);
         instret_i <= 1'b1;
         @(posedge clk_i);
         instret_i <= 1'b0;
      end
      read_csr(csr_pkg::ADDR_MINSTRET);
      check("minstret delta", rd - c0, 64'(n));
      epc_val = {$urandom, $urandom};
      write_csr(csr_pkg::ADDR_MEPC, epc_val);
      write_csr(csr_pkg::ADDR_MSTATUS, 64'h1800);
      issue(csr_pkg::OP_MRET, '0, '0);
      check("return strobe", eret_s, 1'b1);
      check("return epc", epc_s, epc_val);
   endtask

   initial
   begin
      void'($urandom(SEED));
      errors                = 0;
      checks                = 0;
      rst_n_i               = 1'b0;
      csr_cmd_v_i           = 1'b0;
      csr_cmd_op_i          = csr_pkg::OP_NONE;
      csr_cmd_addr_i        = '0;
      csr_cmd_data_i        = '0;
      hartid_i              = {$urandom, $urandom};
      instret_i             = 1'b0;
      exception_v_i         = 1'b0;
      exception_ecode_dec_i = '0;
      exception_pc_i        = '0;
      exception_vaddr_i     = '0;
      exception_instr_i     = '0;
      timer_irq_i           = 1'b0;
      software_irq_i        = 1'b0;
      external_irq_i        = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      rst_n_i <= 1'b1;
      identity_and_access();
      privilege_checks();
      exception_entry();
      interrupt_entry();
      counters_and_return();
      $display("%0d checks, %0d errors, %0d assertion failures",
               checks, errors, DUT.u_assertions.fail_count);
      if (errors == 0 && DUT.u_assertions.fail_count == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule
